/* design/merge_pkg.sv */
`default_nettype none

package merge_pkg;

    // --------------------------------------------------
    // Field widths
    // --------------------------------------------------
    localparam int DATA_W    = 32;
    localparam int LANE_ID_W = 2;
    localparam int COUNT_W   = 16;

    // --------------------------------------------------
    // Packet formats
    // --------------------------------------------------
    // Response beat from one engine lane
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] payload;
    } response_packet_t;

    // Merged request with the payload tagged by its source lane
    typedef struct packed {
        logic                 valid;
        logic [LANE_ID_W-1:0] lane_id;
        logic [DATA_W-1:0]    payload;
    } request_packet_t;

    // Job configuration strobe
    typedef struct packed {
        logic               valid;
        logic [COUNT_W-1:0] count;
    } merge_config_t;

    // --------------------------------------------------
    // Controller states
    // --------------------------------------------------
    typedef enum logic [2:0] {
        MERGE_IDLE,
        MERGE_SETUP,
        MERGE_BUSY,
        MERGE_PAUSE,
        MERGE_DONE
    } merge_state_t;

endpackage : merge_pkg

`default_nettype wire

/* design/lane_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_fifo #(
    parameter type payload_t  = logic,
    parameter int  FIFO_DEPTH = 16
) (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  logic                          push,
    input  payload_t                      push_data,
    input  logic                          pop,
    output payload_t                      pop_data,
    output logic                          empty,
    output logic [$clog2(FIFO_DEPTH):0]   level
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    payload_t mem [FIFO_DEPTH];

    // Pointers carry one extra bit to tell full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            pop_ok;

    // Popping an empty FIFO has no effect
    assign pop_ok = pop && !empty;

    // --------------------------------------------------
    // Pointer update
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= push_data;
        end
    end

    // --------------------------------------------------
    // Status and read port
    // --------------------------------------------------
    // Head entry visible in the same cycle as pop
    assign pop_data = mem[rd_ptr[ADDR_W-1:0]];
    assign empty    = (wr_ptr == rd_ptr);
    assign level    = wr_ptr - rd_ptr;

endmodule : lane_fifo

`default_nettype wire

/* design/lane_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_arbiter
    import merge_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  logic                  merge_enable,
    input  logic [NUM_LANES-1:0]  lane_empty,
    input  response_packet_t      lane_data [NUM_LANES],
    output logic [NUM_LANES-1:0]  lane_pop,
    output logic [NUM_LANES-1:0]  lane_credit,
    output logic                  push,
    output request_packet_t       push_packet
);

    logic [LANE_ID_W-1:0] last_grant;
    logic [LANE_ID_W-1:0] grant_id;
    logic                 grant_valid;

    // --------------------------------------------------
    // Round-robin search
    // --------------------------------------------------
    // Scan starts at the lane after the last grant
    always_comb begin : find_next
        int idx;
        grant_valid = 1'b0;
        grant_id    = '0;
        for (int k = 1; k <= NUM_LANES; k++) begin
            idx = (int'(last_grant) + k) % NUM_LANES;
            if (!grant_valid && !lane_empty[idx]) begin
                grant_valid = 1'b1;
                grant_id    = LANE_ID_W'(idx);
            end
        end
    end

    // At most one pop per cycle while the controller allows it
    always_comb begin
        lane_pop = '0;
        if (merge_enable && grant_valid) begin
            lane_pop[grant_id] = 1'b1;
        end
    end

    // --------------------------------------------------
    // Registered push and credit return
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push_packet.valid <= 1'b0;
            lane_credit       <= '0;
            last_grant        <= LANE_ID_W'(NUM_LANES - 1);
        end else begin
            push_packet.valid <= |lane_pop;
            lane_credit       <= lane_pop;
            if (|lane_pop) begin
                last_grant <= grant_id;
            end
        end
    end

    // Tag the head payload with its lane number
    always_ff @(posedge ap_clk) begin
        push_packet.lane_id <= grant_id;
        push_packet.payload <= lane_data[grant_id].payload;
    end

    assign push = push_packet.valid;

endmodule : lane_arbiter

`default_nettype wire

/* design/merge_control.sv */
`timescale 1ns/1ps
`default_nettype none

module merge_control
    import merge_pkg::*;
(
    input  logic          ap_clk,
    input  logic          areset_generator,
    input  merge_config_t config_in,
    input  logic          popped,
    input  logic          sent,
    input  logic          prog_full,
    output logic          merge_enable,
    output logic          done
);

    merge_state_t state;
    merge_state_t state_next;

    logic [COUNT_W-1:0] job_count;
    logic [COUNT_W-1:0] popped_cnt;
    logic [COUNT_W-1:0] sent_cnt;
    logic [COUNT_W:0]   popped_total;
    logic               job_sent;

    // --------------------------------------------------
    // State register and next state
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= MERGE_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign job_sent = (sent_cnt == job_count);

    always_comb begin
        state_next = state;
        case (state)
            MERGE_IDLE: begin
                if (config_in.valid) begin
                    state_next = MERGE_SETUP;
                end
            end
            MERGE_SETUP: begin
                state_next = MERGE_BUSY;
            end
            MERGE_BUSY: begin
                if (job_sent) begin
                    state_next = MERGE_DONE;
                end else if (prog_full) begin
                    state_next = MERGE_PAUSE;
                end
            end
            MERGE_PAUSE: begin
                if (job_sent) begin
                    state_next = MERGE_DONE;
                end else if (!prog_full) begin
                    state_next = MERGE_BUSY;
                end
            end
            MERGE_DONE: begin
                state_next = MERGE_IDLE;
            end
            default: begin
                state_next = MERGE_IDLE;
            end
        endcase
    end

    // --------------------------------------------------
    // Job count and progress counters
    // --------------------------------------------------
    // Count taken from the strobe that starts the job
    always_ff @(posedge ap_clk) begin
        if (state == MERGE_IDLE && config_in.valid) begin
            job_count <= config_in.count;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator || state == MERGE_SETUP) begin
            popped_cnt <= '0;
            sent_cnt   <= '0;
        end else begin
            popped_cnt <= popped_cnt + COUNT_W'(popped);
            sent_cnt   <= sent_cnt + COUNT_W'(sent);
        end
    end

    // The push in flight trails its pop by a cycle and counts as popped
    assign popped_total = {1'b0, popped_cnt} + {{COUNT_W{1'b0}}, popped};
    assign merge_enable = (state == MERGE_BUSY) && (popped_total < {1'b0, job_count});

    // Done flag is high only while in MERGE_DONE
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done <= 1'b0;
        end else begin
            done <= (state_next == MERGE_DONE);
        end
    end

endmodule : merge_control

`default_nettype wire

/* design/request_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module request_sender
    import merge_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 12
) (
    input  logic            ap_clk,
    input  logic            areset_generator,
    input  logic            push,
    input  request_packet_t push_packet,
    input  logic            out_credit,
    output request_packet_t request_out,
    output logic            prog_full,
    output logic            sent
);

    localparam int LEVEL_W = $clog2(FIFO_DEPTH) + 1;

    request_packet_t    fifo_data;
    logic               fifo_empty;
    logic [LEVEL_W-1:0] fifo_level;
    logic [COUNT_W-1:0] credit_cnt;
    logic               send;

    // --------------------------------------------------
    // Output FIFO
    // --------------------------------------------------
    lane_fifo #(
        .payload_t  (request_packet_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push),
        .push_data        (push_packet),
        .pop              (send),
        .pop_data         (fifo_data),
        .empty            (fifo_empty),
        .level            (fifo_level)
    );

    assign prog_full = (fifo_level >= LEVEL_W'(PROG_THRESH));

    // --------------------------------------------------
    // Downstream credits
    // --------------------------------------------------
    assign send = !fifo_empty && (credit_cnt != '0);
    assign sent = send;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            credit_cnt <= '0;
        end else begin
            credit_cnt <= credit_cnt + COUNT_W'(out_credit) - COUNT_W'(send);
        end
    end

    // Registered output beat
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            request_out.valid <= 1'b0;
        end else begin
            request_out.valid <= send;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_out.lane_id <= fifo_data.lane_id;
        request_out.payload <= fifo_data.payload;
    end

endmodule : request_sender

`default_nettype wire

/* design/merge_data_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module merge_data_generator
    import merge_pkg::*;
#(
    parameter int NUM_LANES   = 4,
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 12
) (
    input  logic                 ap_clk,
    input  logic                 areset_generator,
    input  merge_config_t        config_in,
    input  response_packet_t     response_in [NUM_LANES],
    output logic [NUM_LANES-1:0] lane_credit,
    output request_packet_t      request_out,
    input  logic                 out_credit,
    output logic                 done
);

    logic [NUM_LANES-1:0] lane_empty;
    logic [NUM_LANES-1:0] lane_pop;
    response_packet_t     lane_data [NUM_LANES];

    request_packet_t      arb_packet;
    logic                 arb_push;
    logic                 merge_enable;
    logic                 prog_full;
    logic                 sent;

    // --------------------------------------------------
    // Input side with one FIFO per lane
    // --------------------------------------------------
    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        lane_fifo #(
            .payload_t  (response_packet_t),
            .FIFO_DEPTH (FIFO_DEPTH)
        ) in_fifo (
            .ap_clk           (ap_clk),
            .areset_generator (areset_generator),
            .push             (response_in[i].valid),
            .push_data        (response_in[i]),
            .pop              (lane_pop[i]),
            .pop_data         (lane_data[i]),
            .empty            (lane_empty[i]),
            .level            ()
        );
    end

    // --------------------------------------------------
    // Merge core
    // --------------------------------------------------
    lane_arbiter #(
        .NUM_LANES (NUM_LANES)
    ) arbiter (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .merge_enable     (merge_enable),
        .lane_empty       (lane_empty),
        .lane_data        (lane_data),
        .lane_pop         (lane_pop),
        .lane_credit      (lane_credit),
        .push             (arb_push),
        .push_packet      (arb_packet)
    );

    // Arbiter push also counts as one popped packet
    merge_control control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_in        (config_in),
        .popped           (arb_push),
        .sent             (sent),
        .prog_full        (prog_full),
        .merge_enable     (merge_enable),
        .done             (done)
    );

    // --------------------------------------------------
    // Output side
    // --------------------------------------------------
    request_sender #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) sender (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (arb_push),
        .push_packet      (arb_packet),
        .out_credit       (out_credit),
        .request_out      (request_out),
        .prog_full        (prog_full),
        .sent             (sent)
    );

endmodule : merge_data_generator

`default_nettype wire

/* sim/tb_merge_data_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_merge_data_generator
    import merge_pkg::*;
();

    localparam int NUM_LANES       = 4;
    localparam int FIFO_DEPTH      = 16;
    localparam int PROG_THRESH     = 12;
    localparam int CLK_PERIOD      = 20;
    localparam int NUM_JOBS        = 6;
    localparam int MAX_JOB_PKTS    = NUM_LANES * FIFO_DEPTH;
    localparam int GAP_CYCLES      = 80;
    localparam int DS_CREDIT_LIMIT = 4;
    localparam int TIMEOUT_CYCLES  = (NUM_JOBS + 1) * MAX_JOB_PKTS * 200;

    logic                 ap_clk;
    logic                 areset_generator;
    merge_config_t        config_in;
    response_packet_t     response_in [NUM_LANES];
    logic [NUM_LANES-1:0] lane_credit;
    request_packet_t      request_out;
    logic                 out_credit;
    logic                 done;

    // Model state
    int                seed;
    int                lane_credits [NUM_LANES];
    logic [DATA_W-1:0] lane_queue [NUM_LANES][$];
    int                granted;
    int                beats_total;
    int                job_beats;
    int                job_count;
    int                done_count;
    bit                job_active;
    bit                lanes_on;
    bit                credit_on;
    bit                cfg_pending;
    logic [COUNT_W-1:0] cfg_count;

    merge_data_generator #(
        .NUM_LANES   (NUM_LANES),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) dut0 (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_in        (config_in),
        .response_in      (response_in),
        .lane_credit      (lane_credit),
        .request_out      (request_out),
        .out_credit       (out_credit),
        .done             (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the jobs did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s (got 0x%0h, expected 0x%0h)",
                     $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // --------------------------------------------------
    // Scoreboard on sampled outputs
    // --------------------------------------------------
    task automatic monitor_outputs;
        int                lane;
        logic [DATA_W-1:0] expected_data;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_credit[i]) begin
                check_value(64'(lane_credits[i] < FIFO_DEPTH), 64'd1,
                            $sformatf("credit pulse on lane %0d without a matching send", i));
                lane_credits[i]++;
            end
        end
        if (request_out.valid) begin
            beats_total++;
            lane = int'(request_out.lane_id);
            check_value(64'(beats_total <= granted), 64'd1, "more beats than credits granted");
            check_value(64'(job_active), 64'd1, "beat outside a job");
            check_value(64'(lane_queue[lane].size() != 0), 64'd1,
                        $sformatf("beat tagged with lane %0d, which has no pending data", lane));
            expected_data = lane_queue[lane].pop_front();
            check_value(64'(request_out.payload), 64'(expected_data),
                        $sformatf("payload from lane %0d", lane));
            job_beats++;
        end
        if (done) begin
            check_value(64'(job_active), 64'd1, "done outside a job");
            check_value(64'(job_beats), 64'(job_count), "beats sent before done");
            job_active = 1'b0;
            done_count++;
        end
    endtask

    // Lanes only send while they hold a credit
    task automatic drive_inputs;
        for (int i = 0; i < NUM_LANES; i++) begin
            response_in[i] = '0;
            if (lanes_on && lane_credits[i] > 0 && ($random(seed) & 3) == 0) begin
                response_in[i].valid   = 1'b1;
                response_in[i].payload = $random(seed);
                lane_queue[i].push_back(response_in[i].payload);
                lane_credits[i]--;
            end
        end

        // Downstream buffer holds only a few credits at a time
        out_credit = 1'b0;
        if (credit_on && (granted - beats_total) < DS_CREDIT_LIMIT &&
            ($random(seed) & 1) != 0) begin
            out_credit = 1'b1;
            granted++;
        end

        config_in = '0;
        if (cfg_pending) begin
            config_in.valid = 1'b1;
            config_in.count = cfg_count;
            // A strobe during a running job must not touch its count
            if (!job_active) begin
                job_active = 1'b1;
                job_count  = int'(cfg_count);
                job_beats  = 0;
            end
            cfg_pending = 1'b0;
        end
    endtask

    task automatic step;
        @(negedge ap_clk);
        monitor_outputs();
        drive_inputs();
    endtask

    // --------------------------------------------------
    // One job from config strobe to done
    // --------------------------------------------------
    task automatic run_job(input int count, input bit with_gap, input bit with_extra_cfg);
        int k;
        k           = 0;
        cfg_count   = COUNT_W'(count);
        cfg_pending = 1'b1;
        credit_on   = !with_gap;
        step();
        while (job_active) begin
            credit_on = !(with_gap && k < GAP_CYCLES);
            if (with_extra_cfg && k == 3) begin
                cfg_count   = COUNT_W'(count + 7);
                cfg_pending = 1'b1;
            end
            step();
            k++;
        end
        credit_on = 1'b1;
        // Quiet cycles where no beat may leave
        repeat (1 + ($random(seed) & 3)) step();
    endtask

    initial begin
        int count;
        int pending;
        int jobs_run;

        seed             = 32'h7ce6_18f6;
        areset_generator = 1'b1;
        config_in        = '0;
        out_credit       = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            response_in[i]  = '0;
            lane_credits[i] = FIFO_DEPTH;
        end
        granted     = 0;
        beats_total = 0;
        job_beats   = 0;
        job_count   = 0;
        done_count  = 0;
        jobs_run    = 0;
        job_active  = 1'b0;
        lanes_on    = 1'b0;
        credit_on   = 1'b0;
        cfg_pending = 1'b0;
        cfg_count   = '0;

        repeat (5) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_generator = 1'b0;

        // Outputs stay quiet before any stimulus
        repeat (5) begin
            step();
            check_value(64'(request_out.valid), 64'd0, "request_out valid after reset");
            check_value(64'(done), 64'd0, "done after reset");
            check_value(64'(lane_credit), 64'd0, "lane_credit after reset");
        end

        lanes_on  = 1'b1;
        credit_on = 1'b1;
        repeat (10) step();

        for (int j = 0; j < NUM_JOBS; j++) begin
            count = 4 + ($random(seed) & 31);
            if (j == 1) begin
                count = 40;
            end
            if (j == 2 && count < 10) begin
                count = 10;
            end
            run_job(count, j == 1, j == 2);
            jobs_run++;
        end

        // Drain whatever the lanes still hold
        lanes_on = 1'b0;
        step();
        pending = 0;
        for (int i = 0; i < NUM_LANES; i++) begin
            pending += lane_queue[i].size();
        end
        if (pending > 0) begin
            run_job(pending, 1'b0, 1'b0);
            jobs_run++;
        end
        repeat (4) step();

        for (int i = 0; i < NUM_LANES; i++) begin
            check_value(64'(lane_credits[i]), 64'(FIFO_DEPTH),
                        $sformatf("credits of lane %0d after drain", i));
            check_value(64'(lane_queue[i].size()), 64'd0,
                        $sformatf("data left on lane %0d", i));
        end
        check_value(64'(done_count), 64'(jobs_run), "number of done pulses");

        $display("** PASS **");
        $finish;
    end

endmodule : tb_merge_data_generator

`default_nettype wire

/* files.f */
design/merge_pkg.sv
design/lane_fifo.sv
design/lane_arbiter.sv
design/merge_control.sv
design/request_sender.sv
design/merge_data_generator.sv
sim/tb_merge_data_generator.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_merge_data_generator
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
